// ==== bench/mem_patterns.txt ====
// flag (0 load, 1 store, e group end, f end), funct3 or group number,
// byte address, store data, expected load result
1 2 00000000 11223344 00000000
1 2 00000004 55667788 00000000
1 2 00000008 99aabbcc 00000000
1 2 0000000c ddeeff00 00000000
0 2 00000000 00000000 11223344
0 2 00000004 00000000 55667788
0 2 00000008 00000000 99aabbcc
0 2 0000000c 00000000 ddeeff00
1 2 00000400 cafef00d 00000000
1 2 00000010 01020304 00000000
0 2 00000000 00000000 cafef00d
0 2 00000010 00000000 01020304
1 2 8000fff4 a5a5a5a5 00000000
0 2 000003f4 00000000 a5a5a5a5
0 2 00000c0c 00000000 ddeeff00
e 1 00000000 00000000 00000000
1 2 00000020 00000000 00000000
1 0 00000021 deadbe22 00000000
0 2 00000020 00000000 00002200
1 0 00000023 cafe0044 00000000
0 2 00000020 00000000 44002200
1 0 00000020 12345611 00000000
1 0 00000022 9abcde33 00000000
0 2 00000020 00000000 44332211
1 2 00000034 ffffffff 00000000
1 1 00000034 ffff5678 00000000
0 2 00000034 00000000 ffff5678
1 1 00000036 abcd1234 00000000
0 2 00000034 00000000 12345678
e 2 00000000 00000000 00000000
1 2 00000048 8a7fc301 00000000
0 0 00000048 00000000 00000001
0 0 00000049 00000000 ffffffc3
0 0 0000004a 00000000 0000007f
0 0 0000004b 00000000 ffffff8a
0 4 00000049 00000000 000000c3
0 4 0000004b 00000000 0000008a
0 4 00000048 00000000 00000001
0 4 0000004a 00000000 0000007f
0 1 00000048 00000000 ffffc301
0 1 0000004a 00000000 ffff8a7f
0 5 00000048 00000000 0000c301
0 5 0000004a 00000000 00008a7f
1 2 0000005c 7ffe8000 00000000
0 1 0000005e 00000000 00007ffe
0 5 0000005c 00000000 00008000
0 1 0000005c 00000000 ffff8000
e 3 00000000 00000000 00000000
f 0 00000000 00000000 00000000

// ==== verilog.f ====
hw/ladybird_pkg.sv
hw/ladybird_mmu.sv
hw/bank_router.sv
hw/sram_bank.sv
hw/read_merge.sv
hw/ladybird_mem_top.sv
bench/tb_ladybird_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ladybird memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_ladybird_mem
BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert \
    -f verilog.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR"; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== bench/tb_ladybird_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ladybird_mem;

  import ladybird_pkg::*;

  localparam int MAX_PAT    = 64;
  localparam int RST_CYCLES = 10;
  localparam int LOAD_LAT   = 3;
  localparam int MAX_STALL  = 4;

  // Values of the flag column
  localparam logic [31:0] TAG_LOAD  = 32'h0;
  localparam logic [31:0] TAG_STORE = 32'h1;
  localparam logic [31:0] TAG_GROUP = 32'he;
  localparam logic [31:0] TAG_END   = 32'hf;

  logic   clk;
  logic   anrst;
  logic   i_valid;
  logic   i_ready;
  addr_t  i_addr;
  word_t  i_data;
  logic   i_we;
  funct_t i_funct;
  logic   o_valid;
  logic   o_ready;
  word_t  o_data;

  // Five words per access
  logic [31:0] pat [MAX_PAT*5];

  int num_pat;
  int seed;
  int cycle_count;
  int cycle_limit = 0;
  int checks      = 0;
  int errors      = 0;
  int grp_errors  = 0;
  int grp_accesses = 0;
  int lat_loads   = 0;
  int lat_errors  = 0;
  int stall_cycles = 0;
  int bp_errors   = 0;

  ladybird_mem_top DUT (
    .clk     (clk),
    .anrst   (anrst),
    .i_valid (i_valid),
    .i_ready (i_ready),
    .i_addr  (i_addr),
    .i_data  (i_data),
    .i_we    (i_we),
    .i_funct (i_funct),
    .o_valid (o_valid),
    .o_ready (o_ready),
    .o_data  (o_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_limit == 0 || cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("TESTS FAILED");
    $finish;
  end

  task automatic report_mismatch(input string msg);
    $display("FAIL t=%0t: %s", $time, msg);
    errors++;
    grp_errors++;
  endtask

  task automatic check_idle(input string when);
    checks += 2;
    if (i_ready !== 1'b1) begin
      report_mismatch($sformatf("i_ready is not high %s", when));
    end
    if (o_valid !== 1'b0) begin
      report_mismatch($sformatf("o_valid is not low %s", when));
    end
  endtask

  // Waits for i_ready and holds the request for the accepting edge
  task automatic issue(input logic we, input funct_t fn, input addr_t ad, input word_t wd);
    while (!i_ready) begin
      @(posedge clk);
      #2;
    end
    i_valid = 1'b1;
    i_we    = we;
    i_funct = fn;
    i_addr  = ad;
    i_data  = wd;
    @(posedge clk);
    #2;
    i_valid = 1'b0;
  endtask

  task automatic run_load(input funct_t fn, input addr_t ad, input word_t ex);
    int    lat;
    int    lows;
    int    rnd;
    logic  rdy;
    word_t held;
    issue(1'b0, fn, ad, 32'h0);
    lat = 1;
    while (!o_valid) begin
      @(posedge clk);
      #2;
      lat++;
    end
    checks++;
    lat_loads++;
    if (lat != LOAD_LAT) begin
      lat_errors++;
      report_mismatch($sformatf("load at %h: o_valid after %0d cycles, expected %0d",
                                ad, lat, LOAD_LAT));
    end
    held = o_data;
    lows = 0;
    rdy  = 1'b0;
    while (!rdy) begin
      rnd     = $random(seed);
      rdy     = (lows >= MAX_STALL) ? 1'b1 : rnd[0];
      o_ready = rdy;
      if (rdy) begin
        checks++;
        if (o_data !== ex) begin
          report_mismatch($sformatf("load f3=%0d at %h: got %h, expected %h",
                                    fn, ad, o_data, ex));
        end
      end
      @(posedge clk);
      #2;
      if (!rdy) begin
        lows++;
        stall_cycles++;
        checks += 3;
        if (o_valid !== 1'b1) begin
          bp_errors++;
          report_mismatch($sformatf("load at %h: o_valid dropped while stalled", ad));
        end
        if (o_data !== held) begin
          bp_errors++;
          report_mismatch($sformatf("load at %h: o_data moved from %h to %h while stalled",
                                    ad, held, o_data));
        end
        if (i_ready !== 1'b0) begin
          bp_errors++;
          report_mismatch($sformatf("load at %h: i_ready high while stalled", ad));
        end
      end
    end
    o_ready = 1'b0;
    check_idle("the cycle after a response was taken");
  endtask

  function automatic string group_name(input logic [31:0] id);
    case (id)
      32'd1:   return "word store/load";
      32'd2:   return "partial stores";
      32'd3:   return "load extension";
      default: return "unnamed group";
    endcase
  endfunction

  task automatic close_group(input string name);
    $display("%s: %0d accesses, %0d errors", name, grp_accesses, grp_errors);
    grp_accesses = 0;
    grp_errors   = 0;
  endtask

  initial begin
    logic [31:0] tag;
    funct_t      fn;
    addr_t       ad;
    word_t       wd;
    word_t       ex;
    seed    = 32'hbd48b42a;
    anrst   = 1'b0;
    i_valid = 1'b0;
    i_we    = 1'b0;
    i_funct = FUNCT_W;
    i_addr  = '0;
    i_data  = '0;
    o_ready = 1'b0;

    $readmemh("bench/mem_patterns.txt", pat);
    num_pat = 0;
    while (num_pat < MAX_PAT && pat[num_pat*5] != TAG_END) begin
      num_pat++;
    end
    cycle_limit = RST_CYCLES + 12 * num_pat + 100;
    if (num_pat == MAX_PAT) begin
      $display("The pattern file has no end marker, no accesses were run");
      errors++;
      num_pat = 0;
    end

    repeat (RST_CYCLES) begin
      @(posedge clk);
      #2;
      check_idle("during reset");
    end
    anrst = 1'b1;
    @(posedge clk);
    #2;
    check_idle("after reset");
    close_group("reset");

    for (int i = 0; i < num_pat; i++) begin
      tag = pat[i*5];
      fn  = pat[i*5+1][2:0];
      ad  = pat[i*5+2];
      wd  = pat[i*5+3];
      ex  = pat[i*5+4];
      case (tag)
        TAG_STORE: begin
          issue(1'b1, fn, ad, wd);
          grp_accesses++;
        end
        TAG_LOAD: begin
          run_load(fn, ad, ex);
          grp_accesses++;
        end
        TAG_GROUP: begin
          close_group(group_name(pat[i*5+1]));
        end
        default: begin
          $display("Pattern line %0d has an unknown flag value %h", i, tag);
          errors++;
        end
      endcase
    end

    $display("latency: %0d loads, %0d errors", lat_loads, lat_errors);
    $display("back-pressure: %0d stalled cycles, %0d errors", stall_cycles, bp_errors);
    $display("checks: %0d passed, %0d failed", checks - errors, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/ladybird_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ladybird_mem_top (
  input  wire                        clk,
  input  wire                        anrst,
  input  wire                        i_valid,
  output logic                       i_ready,
  input  wire ladybird_pkg::addr_t   i_addr,
  input  wire ladybird_pkg::word_t   i_data,
  input  wire                        i_we,
  input  wire ladybird_pkg::funct_t  i_funct,
  output logic                       o_valid,
  input  wire                        o_ready,
  output ladybird_pkg::word_t        o_data
);

  import ladybird_pkg::*;

  // Internal request bus
  logic  bus_req;
  logic  bus_gnt;
  logic  bus_we;
  addr_t bus_addr;
  word_t bus_wdata;
  strb_t bus_wstrb;

  // Shared bank nets
  logic [NUM_BANKS-1:0] bank_req;
  logic                 bank_we;
  bank_addr_t           bank_waddr;
  word_t                bank_wdata;
  strb_t                bank_wstrb;

  logic [NUM_BANKS-1:0]  bank_rvalid;
  word_t [NUM_BANKS-1:0] bank_rdata;

  logic  rsp_valid;
  word_t rsp_data;
  logic  rsp_taken;

  ladybird_mmu u_mmu (
    .clk         (clk),
    .anrst       (anrst),
    .i_valid     (i_valid),
    .i_ready     (i_ready),
    .i_addr      (i_addr),
    .i_data      (i_data),
    .i_we        (i_we),
    .i_funct     (i_funct),
    .o_valid     (o_valid),
    .o_ready     (o_ready),
    .o_data      (o_data),
    .o_bus_req   (bus_req),
    .i_bus_gnt   (bus_gnt),
    .o_bus_we    (bus_we),
    .o_bus_addr  (bus_addr),
    .o_bus_wdata (bus_wdata),
    .o_bus_wstrb (bus_wstrb),
    .i_rsp_valid (rsp_valid),
    .i_rsp_data  (rsp_data),
    .o_rsp_taken (rsp_taken)
  );

  bank_router u_router (
    .clk          (clk),
    .anrst        (anrst),
    .i_req        (bus_req),
    .i_we         (bus_we),
    .i_addr       (bus_addr),
    .i_wdata      (bus_wdata),
    .i_wstrb      (bus_wstrb),
    .o_gnt        (bus_gnt),
    .o_bank_req   (bank_req),
    .o_bank_we    (bank_we),
    .o_bank_waddr (bank_waddr),
    .o_bank_wdata (bank_wdata),
    .o_bank_wstrb (bank_wstrb)
  );

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    sram_bank u_bank (
      .clk      (clk),
      .anrst    (anrst),
      .i_req    (bank_req[k]),
      .i_we     (bank_we),
      .i_waddr  (bank_waddr),
      .i_wdata  (bank_wdata),
      .i_wstrb  (bank_wstrb),
      .o_rvalid (bank_rvalid[k]),
      .o_rdata  (bank_rdata[k])
    );
  end

  read_merge u_merge (
    .clk           (clk),
    .anrst         (anrst),
    .i_bank_rvalid (bank_rvalid),
    .i_bank_rdata  (bank_rdata),
    .i_taken       (rsp_taken),
    .o_rsp_valid   (rsp_valid),
    .o_rsp_data    (rsp_data)
  );

endmodule

`default_nettype wire

// ==== hw/read_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_merge (
  input  wire                        clk,
  input  wire                        anrst,
  input  wire [ladybird_pkg::NUM_BANKS-1:0] i_bank_rvalid,
  input  wire ladybird_pkg::word_t [ladybird_pkg::NUM_BANKS-1:0] i_bank_rdata,
  input  wire                        i_taken,
  output logic                       o_rsp_valid,
  output ladybird_pkg::word_t        o_rsp_data
);

  import ladybird_pkg::*;

  word_t sel_data;
  logic  any_rvalid;

  assign any_rvalid = |i_bank_rvalid;

  // At most one bank answers
  always_comb begin
    sel_data = '0;
    for (int k = 0; k < NUM_BANKS; k++) begin
      if (i_bank_rvalid[k]) begin
        sel_data = sel_data | i_bank_rdata[k];
      end
    end
  end

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      o_rsp_valid <= 1'b0;
    end else if (any_rvalid) begin
      o_rsp_valid <= 1'b1;
    end else if (i_taken) begin
      o_rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (any_rvalid) begin
      o_rsp_data <= sel_data;
    end
  end

  a_one_bank: assert property (@(posedge clk) disable iff (!anrst)
    $onehot0(i_bank_rvalid))
    else $error("several banks answered: %b", i_bank_rvalid);

  a_no_overrun: assert property (@(posedge clk) disable iff (!anrst)
    any_rvalid |-> !o_rsp_valid)
    else $error("bank data arrived while a response is held");

endmodule

`default_nettype wire

// ==== hw/sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
  input  wire                        clk,
  input  wire                        anrst,
  input  wire                        i_req,
  input  wire                        i_we,
  input  wire ladybird_pkg::bank_addr_t i_waddr,
  input  wire ladybird_pkg::word_t   i_wdata,
  input  wire ladybird_pkg::strb_t   i_wstrb,
  output logic                       o_rvalid,
  output ladybird_pkg::word_t        o_rdata
);

  import ladybird_pkg::*;

  word_t mem [BANK_WORDS];

  logic wr_en;
  logic rd_en;

  assign wr_en = i_req && i_we;
  assign rd_en = i_req && !i_we;

  // Byte-masked write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < XLEN / 8; b++) begin
        if (i_wstrb[b]) begin
          mem[i_waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      o_rdata <= mem[i_waddr];
    end
  end

  // One-cycle read strobe
  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      o_rvalid <= 1'b0;
    end else begin
      o_rvalid <= rd_en;
    end
  end

endmodule

`default_nettype wire

// ==== hw/bank_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_router (
  input  wire                        clk,
  input  wire                        anrst,
  input  wire                        i_req,
  input  wire                        i_we,
  input  wire ladybird_pkg::addr_t   i_addr,
  input  wire ladybird_pkg::word_t   i_wdata,
  input  wire ladybird_pkg::strb_t   i_wstrb,
  output logic                       o_gnt,
  output logic [ladybird_pkg::NUM_BANKS-1:0] o_bank_req,
  output logic                       o_bank_we,
  output ladybird_pkg::bank_addr_t   o_bank_waddr,
  output ladybird_pkg::word_t        o_bank_wdata,
  output ladybird_pkg::strb_t        o_bank_wstrb
);

  import ladybird_pkg::*;

  bank_idx_t bank_idx;

  // Word interleaved, upper address bits alias
  assign bank_idx     = i_addr[3:2];
  assign o_bank_waddr = i_addr[9:4];

  always_comb begin
    o_bank_req = '0;
    if (i_req) begin
      o_bank_req[bank_idx] = 1'b1;
    end
  end

  // Banks never stall
  assign o_gnt = |o_bank_req;

  assign o_bank_we    = i_we;
  assign o_bank_wdata = i_wdata;
  assign o_bank_wstrb = i_wstrb;

  a_bank_onehot: assert property (@(posedge clk) disable iff (!anrst)
    $onehot0(o_bank_req))
    else $error("more than one bank selected: %b", o_bank_req);

endmodule

`default_nettype wire

// ==== hw/ladybird_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ladybird_mmu (
  input  wire                    clk,
  input  wire                    anrst,
  input  wire                    i_valid,
  output logic                   i_ready,
  input  wire ladybird_pkg::addr_t  i_addr,
  input  wire ladybird_pkg::word_t  i_data,
  input  wire                    i_we,
  input  wire ladybird_pkg::funct_t i_funct,
  output logic                   o_valid,
  input  wire                    o_ready,
  output ladybird_pkg::word_t    o_data,
  output logic                   o_bus_req,
  input  wire                    i_bus_gnt,
  output logic                   o_bus_we,
  output ladybird_pkg::addr_t    o_bus_addr,
  output ladybird_pkg::word_t    o_bus_wdata,
  output ladybird_pkg::strb_t    o_bus_wstrb,
  input  wire                    i_rsp_valid,
  input  wire ladybird_pkg::word_t  i_rsp_data,
  output logic                   o_rsp_taken
);

  import ladybird_pkg::*;

  mmu_state_t state;

  // One-entry request buffer
  logic   buf_we;
  funct_t buf_funct;
  addr_t  buf_addr;
  word_t  buf_data;

  logic [1:0] lane;
  word_t      wdata_aligned;
  strb_t      wstrb;
  word_t      rsp_shifted;

  assign i_ready = (state == MMU_IDLE);
  assign lane    = buf_addr[1:0];

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      state <= MMU_IDLE;
    end else begin
      case (state)
        MMU_IDLE: begin
          if (i_valid) begin
            state <= MMU_REQ;
          end
        end
        MMU_REQ: begin
          // Stores complete on grant, loads wait for data
          if (i_bus_gnt) begin
            state <= buf_we ? MMU_IDLE : MMU_RESP;
          end
        end
        MMU_RESP: begin
          if (o_rsp_taken) begin
            state <= MMU_IDLE;
          end
        end
        default: begin
          state <= MMU_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && i_ready) begin
      buf_we    <= i_we;
      buf_funct <= i_funct;
      buf_addr  <= i_addr;
      buf_data  <= i_data;
    end
  end

  // Replicate store data across the word, strobe picks the lanes
  always_comb begin
    case (buf_funct)
      FUNCT_B: begin
        wdata_aligned = {4{buf_data[7:0]}};
        wstrb         = strb_t'(4'b0001 << lane);
      end
      FUNCT_H: begin
        wdata_aligned = {2{buf_data[15:0]}};
        wstrb         = strb_t'(4'b0011 << lane);
      end
      default: begin
        wdata_aligned = buf_data;
        wstrb         = 4'b1111;
      end
    endcase
  end

  assign o_bus_req   = (state == MMU_REQ);
  assign o_bus_we    = buf_we;
  assign o_bus_addr  = buf_addr;
  assign o_bus_wdata = wdata_aligned;
  assign o_bus_wstrb = buf_we ? wstrb : '0;

  // Load extraction and extension
  assign rsp_shifted = i_rsp_data >> {lane, 3'b000};

  always_comb begin
    case (buf_funct)
      FUNCT_B:  o_data = {{(XLEN-8){rsp_shifted[7]}}, rsp_shifted[7:0]};
      FUNCT_H:  o_data = {{(XLEN-16){rsp_shifted[15]}}, rsp_shifted[15:0]};
      FUNCT_BU: o_data = {{(XLEN-8){1'b0}}, rsp_shifted[7:0]};
      FUNCT_HU: o_data = {{(XLEN-16){1'b0}}, rsp_shifted[15:0]};
      default:  o_data = i_rsp_data;
    endcase
  end

  assign o_valid     = (state == MMU_RESP) && i_rsp_valid;
  assign o_rsp_taken = o_valid && o_ready;

  a_aligned: assert property (@(posedge clk) disable iff (!anrst)
    (i_valid && i_ready) |->
      !((i_funct == FUNCT_H || i_funct == FUNCT_HU) && i_addr[0]) &&
      !(i_funct == FUNCT_W && i_addr[1:0] != 2'b00))
    else $error("misaligned access at %h", i_addr);

  a_rsp_stable: assert property (@(posedge clk) disable iff (!anrst)
    (o_valid && !o_ready) |=> $stable(o_data))
    else $error("load data changed under back-pressure");

endmodule

`default_nettype wire

// ==== hw/ladybird_pkg.sv ====
`default_nettype none

package ladybird_pkg;

  localparam int XLEN = 32;

  // Word-interleaved banks
  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 64;

  // RISC-V load/store funct3
  localparam logic [2:0] FUNCT_B  = 3'b000;
  localparam logic [2:0] FUNCT_H  = 3'b001;
  localparam logic [2:0] FUNCT_W  = 3'b010;
  localparam logic [2:0] FUNCT_BU = 3'b100;
  localparam logic [2:0] FUNCT_HU = 3'b101;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN/8-1:0] strb_t;
  typedef logic [2:0] funct_t;

  // Address bits 3..2
  typedef logic [1:0] bank_idx_t;

  // Address bits 9..4
  typedef logic [5:0] bank_addr_t;

  typedef enum logic [1:0] {
    MMU_IDLE,
    MMU_REQ,
    MMU_RESP
  } mmu_state_t;

endpackage

`default_nettype wire
